//--- logic/obi_mem_pkg.sv
`default_nettype none

package obi_mem_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Word index sits just above the byte offset
  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int WORD_LSB  = $clog2(BE_W);
  localparam int COUNT_W   = IDX_W + 1;

  // AXI response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Master to memory
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // Memory to master
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

  // Fill command with a count of 1 to MEM_WORDS words
  typedef struct packed {
    logic [IDX_W-1:0]   base;
    logic [COUNT_W-1:0] count;
    logic [DATA_W-1:0]  pattern;
  } fill_cmd_t;

endpackage

`default_nettype wire

//--- logic/axi2obi.sv
`timescale 1ns/1ps
`default_nettype none

module axi2obi (
  input  wire                                s00_axi_aclk,
  input  wire                                s00_axi_aresetn,

  // Read address channel
  input  wire  [obi_mem_pkg::ADDR_W-1:0]     s00_axi_araddr_i,
  input  wire                                s00_axi_arvalid_i,
  input  wire  [2:0]                         s00_axi_arprot_i,
  output logic                               s00_axi_arready_o,

  // Read data channel
  output logic [obi_mem_pkg::DATA_W-1:0]     s00_axi_rdata_o,
  output logic [1:0]                         s00_axi_rresp_o,
  output logic                               s00_axi_rvalid_o,
  input  wire                                s00_axi_rready_i,

  // Write address channel
  input  wire  [obi_mem_pkg::ADDR_W-1:0]     s00_axi_awaddr_i,
  input  wire                                s00_axi_awvalid_i,
  input  wire  [2:0]                         s00_axi_awprot_i,
  output logic                               s00_axi_awready_o,

  // Write data channel
  input  wire  [obi_mem_pkg::DATA_W-1:0]     s00_axi_wdata_i,
  input  wire  [obi_mem_pkg::BE_W-1:0]       s00_axi_wstrb_i,
  input  wire                                s00_axi_wvalid_i,
  output logic                               s00_axi_wready_o,

  // Write response channel
  output logic [1:0]                         s00_axi_bresp_o,
  output logic                               s00_axi_bvalid_o,
  input  wire                                s00_axi_bready_i,

  // OBI master side
  output obi_mem_pkg::obi_req_t              obi_req_o,
  input  wire obi_mem_pkg::obi_rsp_t         obi_rsp_i
);

  typedef enum logic [2:0] {
    IDLE,
    READ1,
    READ2,
    READ3,
    WRITE1,
    WRITE2,
    WRITE3
  } state_t;

  state_t state_q;
  state_t state_d;

  logic [obi_mem_pkg::ADDR_W-1:0] addr_q;
  logic [obi_mem_pkg::DATA_W-1:0] wdata_q;
  logic [obi_mem_pkg::BE_W-1:0]   be_q;
  logic [obi_mem_pkg::DATA_W-1:0] rdata_q;

  logic take_read;
  logic take_write;
  logic write_phase;

  // Read has priority when both channels are pending in IDLE
  assign take_read  = (state_q == IDLE) && s00_axi_arvalid_i;
  assign take_write = (state_q == IDLE) && !s00_axi_arvalid_i &&
                      s00_axi_awvalid_i && s00_axi_wvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (take_read) begin
          state_d = READ1;
        end else if (take_write) begin
          state_d = WRITE1;
        end
      end
      READ1: begin
        if (obi_rsp_i.gnt) begin
          state_d = READ2;
        end
      end
      READ2: begin
        if (obi_rsp_i.rvalid) begin
          state_d = READ3;
        end
      end
      READ3: begin
        if (s00_axi_rready_i) begin
          state_d = IDLE;
        end
      end
      WRITE1: begin
        if (obi_rsp_i.gnt) begin
          state_d = WRITE2;
        end
      end
      WRITE2: begin
        if (obi_rsp_i.rvalid) begin
          state_d = WRITE3;
        end
      end
      WRITE3: begin
        if (s00_axi_bready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured on the address handshake
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      addr_q  <= '0;
      wdata_q <= '0;
      be_q    <= '0;
    end else if (take_read) begin
      addr_q <= s00_axi_araddr_i;
    end else if (take_write) begin
      addr_q  <= s00_axi_awaddr_i;
      wdata_q <= s00_axi_wdata_i;
      be_q    <= s00_axi_wstrb_i;
    end
  end

  // Held stable through R back-pressure
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      rdata_q <= '0;
    end else if ((state_q == READ2) && obi_rsp_i.rvalid) begin
      rdata_q <= obi_rsp_i.rdata;
    end
  end

  assign write_phase = (state_q == WRITE1) || (state_q == WRITE2);

  always_comb begin
    obi_req_o.req   = (state_q == READ1) || (state_q == WRITE1);
    obi_req_o.we    = write_phase;
    // Reads fetch the full word
    obi_req_o.be    = write_phase ? be_q : '1;
    obi_req_o.addr  = addr_q;
    obi_req_o.wdata = wdata_q;
  end

  assign s00_axi_arready_o = take_read;
  assign s00_axi_awready_o = take_write;
  assign s00_axi_wready_o  = take_write;

  assign s00_axi_rvalid_o = (state_q == READ3);
  assign s00_axi_rdata_o  = rdata_q;
  assign s00_axi_rresp_o  = obi_mem_pkg::RESP_OKAY;

  assign s00_axi_bvalid_o = (state_q == WRITE3);
  assign s00_axi_bresp_o  = obi_mem_pkg::RESP_OKAY;

endmodule

`default_nettype wire

//--- logic/fill_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fill_engine (
  input  wire                            s00_axi_aclk,
  input  wire                            s00_axi_aresetn,
  input  wire                            fill_req_i,
  input  wire obi_mem_pkg::fill_cmd_t    fill_cmd_i,
  output logic                           fill_ack_o,
  output obi_mem_pkg::obi_req_t          obi_req_o,
  input  wire obi_mem_pkg::obi_rsp_t     obi_rsp_i
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_ISSUE,
    F_WAIT,
    F_ACK
  } state_t;

  state_t state_q;
  state_t state_d;

  obi_mem_pkg::fill_cmd_t          cmd_q;
  logic [obi_mem_pkg::COUNT_W-1:0] offset_q;
  logic [obi_mem_pkg::IDX_W-1:0]   word_idx;
  logic                            last_word;

  // Index wraps at the top of the memory
  assign word_idx  = cmd_q.base + offset_q[obi_mem_pkg::IDX_W-1:0];
  assign last_word = (offset_q + 1'b1) == cmd_q.count;

  always_comb begin
    state_d = state_q;
    case (state_q)
      F_IDLE: begin
        if (fill_req_i) begin
          state_d = F_ISSUE;
        end
      end
      F_ISSUE: begin
        if (obi_rsp_i.gnt) begin
          state_d = F_WAIT;
        end
      end
      F_WAIT: begin
        if (obi_rsp_i.rvalid) begin
          state_d = last_word ? F_ACK : F_ISSUE;
        end
      end
      F_ACK: begin
        // Requester closes the handshake
        if (!fill_req_i) begin
          state_d = F_IDLE;
        end
      end
      default: begin
        state_d = F_IDLE;
      end
    endcase
  end

  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      state_q  <= F_IDLE;
      offset_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == F_IDLE) begin
        offset_q <= '0;
      end else if ((state_q == F_WAIT) && obi_rsp_i.rvalid && !last_word) begin
        offset_q <= offset_q + 1'b1;
      end
    end
  end

  // Command sampled once at the start of a fill
  always_ff @(posedge s00_axi_aclk) begin
    if ((state_q == F_IDLE) && fill_req_i) begin
      cmd_q <= fill_cmd_i;
    end
  end

  always_comb begin
    obi_req_o       = '0;
    obi_req_o.req   = (state_q == F_ISSUE);
    obi_req_o.we    = 1'b1;
    obi_req_o.be    = '1;
    obi_req_o.addr[obi_mem_pkg::WORD_LSB +: obi_mem_pkg::IDX_W] = word_idx;
    // Offset zero-extends to the data width
    obi_req_o.wdata = cmd_q.pattern + offset_q;
  end

  assign fill_ack_o = (state_q == F_ACK);

endmodule

`default_nettype wire

//--- logic/obi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
  input  wire                            s00_axi_aclk,
  input  wire                            s00_axi_aresetn,
  input  wire obi_mem_pkg::obi_req_t     m0_req_i,
  input  wire obi_mem_pkg::obi_req_t     m1_req_i,
  output obi_mem_pkg::obi_rsp_t          m0_rsp_o,
  output obi_mem_pkg::obi_rsp_t          m1_rsp_o,
  output obi_mem_pkg::obi_req_t          mem_req_o,
  input  wire obi_mem_pkg::obi_rsp_t     mem_rsp_i
);

  logic busy_q;
  // Last winner and owner while busy
  // Set when the fill engine won
  logic last_q;
  logic pick;
  logic sel;
  logic any_req;

  assign any_req = m0_req_i.req || m1_req_i.req;

  // Alternate when both masters are waiting
  always_comb begin
    if (m0_req_i.req && m1_req_i.req) begin
      pick = ~last_q;
    end else begin
      pick = m1_req_i.req;
    end
  end

  assign sel = busy_q ? last_q : pick;

  always_comb begin
    mem_req_o     = sel ? m1_req_i : m0_req_i;
    mem_req_o.req = !busy_q && any_req;
  end

  // Only the owner sees gnt and rvalid
  always_comb begin
    m0_rsp_o        = mem_rsp_i;
    m1_rsp_o        = mem_rsp_i;
    m0_rsp_o.gnt    = mem_rsp_i.gnt && !busy_q && !sel;
    m1_rsp_o.gnt    = mem_rsp_i.gnt && !busy_q && sel;
    m0_rsp_o.rvalid = mem_rsp_i.rvalid && busy_q && !last_q;
    m1_rsp_o.rvalid = mem_rsp_i.rvalid && busy_q && last_q;
  end

  // Bridge goes first after reset
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      busy_q <= 1'b0;
      last_q <= 1'b1;
    end else if (!busy_q && any_req && mem_rsp_i.gnt) begin
      busy_q <= 1'b1;
      last_q <= pick;
    end else if (busy_q && mem_rsp_i.rvalid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/obi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module obi_sram (
  input  wire                            s00_axi_aclk,
  input  wire                            s00_axi_aresetn,
  input  wire obi_mem_pkg::obi_req_t     mem_req_i,
  output obi_mem_pkg::obi_rsp_t          mem_rsp_o
);

  logic [obi_mem_pkg::DATA_W-1:0] mem_q [obi_mem_pkg::MEM_WORDS];
  logic [obi_mem_pkg::IDX_W-1:0]  word_idx;
  logic [obi_mem_pkg::DATA_W-1:0] rdata_q;
  logic                           rvalid_q;

  // Upper address bits alias
  assign word_idx = mem_req_i.addr[obi_mem_pkg::WORD_LSB +: obi_mem_pkg::IDX_W];

  always_ff @(posedge s00_axi_aclk) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        for (int b = 0; b < obi_mem_pkg::BE_W; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // One response the cycle after each accepted request
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_req_i.req;
    end
  end

  always_comb begin
    // Always ready
    mem_rsp_o.gnt    = mem_req_i.req;
    mem_rsp_o.rvalid = rvalid_q;
    mem_rsp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire

//--- logic/axi_obi_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module axi_obi_subsys (
  input  wire                                s00_axi_aclk,
  input  wire                                s00_axi_aresetn,
  input  wire  [obi_mem_pkg::ADDR_W-1:0]     s00_axi_araddr_i,
  input  wire                                s00_axi_arvalid_i,
  input  wire  [2:0]                         s00_axi_arprot_i,
  output logic                               s00_axi_arready_o,
  output logic [obi_mem_pkg::DATA_W-1:0]     s00_axi_rdata_o,
  output logic [1:0]                         s00_axi_rresp_o,
  output logic                               s00_axi_rvalid_o,
  input  wire                                s00_axi_rready_i,
  input  wire  [obi_mem_pkg::ADDR_W-1:0]     s00_axi_awaddr_i,
  input  wire                                s00_axi_awvalid_i,
  input  wire  [2:0]                         s00_axi_awprot_i,
  output logic                               s00_axi_awready_o,
  input  wire  [obi_mem_pkg::DATA_W-1:0]     s00_axi_wdata_i,
  input  wire  [obi_mem_pkg::BE_W-1:0]       s00_axi_wstrb_i,
  input  wire                                s00_axi_wvalid_i,
  output logic                               s00_axi_wready_o,
  output logic [1:0]                         s00_axi_bresp_o,
  output logic                               s00_axi_bvalid_o,
  input  wire                                s00_axi_bready_i,

  // Fill command handshake
  input  wire                                fill_req_i,
  input  wire obi_mem_pkg::fill_cmd_t        fill_cmd_i,
  output logic                               fill_ack_o
);

  // Master 0 is the bridge, master 1 the fill engine
  obi_mem_pkg::obi_req_t m0_req;
  obi_mem_pkg::obi_req_t m1_req;
  obi_mem_pkg::obi_req_t mem_req;
  obi_mem_pkg::obi_rsp_t m0_rsp;
  obi_mem_pkg::obi_rsp_t m1_rsp;
  obi_mem_pkg::obi_rsp_t mem_rsp;

  axi2obi u_axi2obi (
    .s00_axi_aclk      (s00_axi_aclk),
    .s00_axi_aresetn   (s00_axi_aresetn),
    .s00_axi_araddr_i  (s00_axi_araddr_i),
    .s00_axi_arvalid_i (s00_axi_arvalid_i),
    .s00_axi_arprot_i  (s00_axi_arprot_i),
    .s00_axi_arready_o (s00_axi_arready_o),
    .s00_axi_rdata_o   (s00_axi_rdata_o),
    .s00_axi_rresp_o   (s00_axi_rresp_o),
    .s00_axi_rvalid_o  (s00_axi_rvalid_o),
    .s00_axi_rready_i  (s00_axi_rready_i),
    .s00_axi_awaddr_i  (s00_axi_awaddr_i),
    .s00_axi_awvalid_i (s00_axi_awvalid_i),
    .s00_axi_awprot_i  (s00_axi_awprot_i),
    .s00_axi_awready_o (s00_axi_awready_o),
    .s00_axi_wdata_i   (s00_axi_wdata_i),
    .s00_axi_wstrb_i   (s00_axi_wstrb_i),
    .s00_axi_wvalid_i  (s00_axi_wvalid_i),
    .s00_axi_wready_o  (s00_axi_wready_o),
    .s00_axi_bresp_o   (s00_axi_bresp_o),
    .s00_axi_bvalid_o  (s00_axi_bvalid_o),
    .s00_axi_bready_i  (s00_axi_bready_i),
    .obi_req_o         (m0_req),
    .obi_rsp_i         (m0_rsp)
  );

  fill_engine u_fill_engine (
    .s00_axi_aclk    (s00_axi_aclk),
    .s00_axi_aresetn (s00_axi_aresetn),
    .fill_req_i      (fill_req_i),
    .fill_cmd_i      (fill_cmd_i),
    .fill_ack_o      (fill_ack_o),
    .obi_req_o       (m1_req),
    .obi_rsp_i       (m1_rsp)
  );

  obi_arbiter u_obi_arbiter (
    .s00_axi_aclk    (s00_axi_aclk),
    .s00_axi_aresetn (s00_axi_aresetn),
    .m0_req_i        (m0_req),
    .m1_req_i        (m1_req),
    .m0_rsp_o        (m0_rsp),
    .m1_rsp_o        (m1_rsp),
    .mem_req_o       (mem_req),
    .mem_rsp_i       (mem_rsp)
  );

  obi_sram u_obi_sram (
    .s00_axi_aclk    (s00_axi_aclk),
    .s00_axi_aresetn (s00_axi_aresetn),
    .mem_req_i       (mem_req),
    .mem_rsp_o       (mem_rsp)
  );

endmodule

`default_nettype wire

//--- sim/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// One AXI4-Lite read with a random rready delay
task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
  int          delay;
  logic [31:0] held;
  @(posedge s00_axi_aclk);
  #2;
  araddr  = addr;
  arvalid = 1'b1;
  @(negedge s00_axi_aclk);
  while (!arready) @(negedge s00_axi_aclk);
  @(posedge s00_axi_aclk);
  #2;
  arvalid = 1'b0;
  @(negedge s00_axi_aclk);
  while (!rvalid) @(negedge s00_axi_aclk);
  held = rdata;
  take_bits(3, delay);
  repeat (delay) begin
    @(negedge s00_axi_aclk);
    assert (rvalid === 1'b1) else begin
      $display("rvalid dropped while rready was still low");
      errors++;
    end
    assert (rdata === held) else begin
      $display("mismatch s00_axi_rdata_o: got %h expected %h", rdata, held);
      errors++;
    end
  end
  @(posedge s00_axi_aclk);
  #2;
  rready = 1'b1;
  @(negedge s00_axi_aclk);
  assert (rvalid === 1'b1 && rdata === held) else begin
    $display("read data did not stay valid up to the rready handshake");
    errors++;
  end
  assert (rresp === 2'b00) else begin
    $display("mismatch s00_axi_rresp_o: got %h expected %h", rresp, 2'b00);
    errors++;
  end
  @(posedge s00_axi_aclk);
  #2;
  rready = 1'b0;
  data   = held;
endtask

// One AXI4-Lite write with a random bready delay
task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
  int delay;
  @(posedge s00_axi_aclk);
  #2;
  awaddr  = addr;
  wdata   = data;
  wstrb   = strb;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  @(negedge s00_axi_aclk);
  while (!awready) @(negedge s00_axi_aclk);
  assert (wready === 1'b1) else begin
    $display("awready rose without wready in the same cycle");
    errors++;
  end
  @(posedge s00_axi_aclk);
  #2;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  @(negedge s00_axi_aclk);
  while (!bvalid) @(negedge s00_axi_aclk);
  take_bits(3, delay);
  repeat (delay) begin
    @(negedge s00_axi_aclk);
    assert (bvalid === 1'b1) else begin
      $display("bvalid dropped while bready was still low");
      errors++;
    end
  end
  @(posedge s00_axi_aclk);
  #2;
  bready = 1'b1;
  @(negedge s00_axi_aclk);
  assert (bvalid === 1'b1) else begin
    $display("bvalid was gone before the bready handshake");
    errors++;
  end
  assert (bresp === 2'b00) else begin
    $display("mismatch s00_axi_bresp_o: got %h expected %h", bresp, 2'b00);
    errors++;
  end
  @(posedge s00_axi_aclk);
  #2;
  bready = 1'b0;
endtask

// Four-phase fill command running in the background
task automatic fill_handshake();
  @(posedge s00_axi_aclk);
  #2;
  fill_cmd.base    = fill_base;
  fill_cmd.count   = fill_count;
  fill_cmd.pattern = fill_pattern;
  fill_req         = 1'b1;
  @(negedge s00_axi_aclk);
  assert (fill_ack === 1'b0) else begin
    $display("fill_ack_o was already high when fill_req_i rose");
    fill_errs++;
  end
  while (!fill_ack) @(negedge s00_axi_aclk);
  @(posedge s00_axi_aclk);
  #2;
  fill_req = 1'b0;
  @(negedge s00_axi_aclk);
  assert (fill_ack === 1'b1) else begin
    $display("fill_ack_o fell before the engine could see fill_req_i drop");
    fill_errs++;
  end
  @(negedge s00_axi_aclk);
  assert (fill_ack === 1'b0) else begin
    $display("fill_ack_o stayed high one cycle after fill_req_i dropped");
    fill_errs++;
  end
endtask

`endif

//--- sim/tb_axi_obi_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_obi_subsys;

  // One line of the golden file
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] aux;
    logic [31:0] exp_data;
  } vec_t;

  logic        s00_axi_aclk;
  logic        s00_axi_aresetn;
  logic [31:0] araddr;
  logic        arvalid;
  logic [2:0]  arprot;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [31:0] awaddr;
  logic        awvalid;
  logic [2:0]  awprot;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic        fill_req;
  logic        fill_ack;
  obi_mem_pkg::fill_cmd_t fill_cmd;

  vec_t        vecs[$];
  int          vec_count;
  int          errors;
  int          pass_count;
  int          fail_count;
  string       cur_op;
  logic [31:0] lfsr_state;

  // Background fill bookkeeping
  logic        fill_pending;
  logic        fill_busy;
  int          fill_errs;
  int          fill_line;
  logic [7:0]  fill_base;
  logic [8:0]  fill_count;
  logic [31:0] fill_pattern;

  // Write history used to cross-check the golden file
  logic [31:0] model [256];
  logic        known [256];

  axi_obi_subsys u_axi_obi_subsys (
    .s00_axi_aclk      (s00_axi_aclk),
    .s00_axi_aresetn   (s00_axi_aresetn),
    .s00_axi_araddr_i  (araddr),
    .s00_axi_arvalid_i (arvalid),
    .s00_axi_arprot_i  (arprot),
    .s00_axi_arready_o (arready),
    .s00_axi_rdata_o   (rdata),
    .s00_axi_rresp_o   (rresp),
    .s00_axi_rvalid_o  (rvalid),
    .s00_axi_rready_i  (rready),
    .s00_axi_awaddr_i  (awaddr),
    .s00_axi_awvalid_i (awvalid),
    .s00_axi_awprot_i  (awprot),
    .s00_axi_awready_o (awready),
    .s00_axi_wdata_i   (wdata),
    .s00_axi_wstrb_i   (wstrb),
    .s00_axi_wvalid_i  (wvalid),
    .s00_axi_wready_o  (wready),
    .s00_axi_bresp_o   (bresp),
    .s00_axi_bvalid_o  (bvalid),
    .s00_axi_bready_i  (bready),
    .fill_req_i        (fill_req),
    .fill_cmd_i        (fill_cmd),
    .fill_ack_o        (fill_ack)
  );

  initial begin
    s00_axi_aclk = 1'b0;
    forever #20 s00_axi_aclk = ~s00_axi_aclk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
  endtask

  `include "tb_axi_tasks.svh"

  task automatic load_golden(output logic ok);
    int          fd;
    int          r;
    logic [7:0]  op;
    string       line;
    vec_t        v;
    ok = 1'b0;
    fd = $fopen("sim/golden_vectors.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, " %c", op) == 1) begin
        if (op == "#") begin
          r = $fgets(line, fd);
        end else begin
          v.op = op;
          r = $fscanf(fd, "%h %h %h %h", v.addr, v.data, v.aux, v.exp_data);
          if (r == 4) begin
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
      vec_count = vecs.size();
    end
  endtask

  task automatic expect_low(input string name, input logic val);
    assert (val === 1'b0) else begin
      $display("mismatch %s: got %h expected %h", name, val, 1'b0);
      errors++;
    end
  endtask

  task automatic end_test(input int id, input string what, input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("test %0d %s: ok", id, what);
    end else begin
      fail_count++;
      $display("test %0d %s: FAILED", id, what);
    end
  endtask

  // Strobes merge over the word last written
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [7:0] idx;
    idx = addr[9:2];
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    known[idx] = known[idx] || (strb == 4'hf);
  endtask

  task automatic model_check(input logic [31:0] addr, input logic [31:0] exp_data);
    logic [7:0] idx;
    idx = addr[9:2];
    assert (!known[idx] || model[idx] === exp_data) else begin
      $display("golden value %h for word %0d disagrees with write history %h",
               exp_data, idx, model[idx]);
      errors++;
    end
  endtask

  task automatic start_fill(input int line_no, input vec_t v);
    fill_line    = line_no;
    fill_base    = v.addr[7:0];
    fill_count   = v.aux[8:0];
    fill_pattern = v.data;
    fill_errs    = 0;
    fill_pending = 1'b1;
    fill_busy    = 1'b1;
    fork
      begin
        fill_handshake();
        fill_busy = 1'b0;
      end
    join_none
  endtask

  // Every filled word reads back as pattern plus offset
  task automatic finish_fill();
    logic [31:0] rd;
    logic [31:0] exp_data;
    logic [7:0]  idx;
    int          errs_before;
    errs_before = errors;
    cur_op = $sformatf("fill handshake from line %0d", fill_line);
    wait (!fill_busy);
    errors += fill_errs;
    cur_op = $sformatf("read-back of fill from line %0d", fill_line);
    for (int k = 0; k < fill_count; k++) begin
      idx      = fill_base + k;
      exp_data = fill_pattern + k;
      axi_read({22'd0, idx, 2'b00}, rd);
      assert (rd === exp_data) else begin
        $display("mismatch s00_axi_rdata_o: got %h expected %h", rd, exp_data);
        errors++;
      end
      model[idx] = exp_data;
      known[idx] = 1'b1;
    end
    fill_pending = 1'b0;
    end_test(fill_line, $sformatf("F base %h count %0d pattern %h",
             fill_base, fill_count, fill_pattern), errs_before);
  endtask

  initial begin
    vec_t        v;
    logic [31:0] rd;
    int          errs_before;
    logic        load_ok;
    s00_axi_aresetn = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    arprot  = '0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    awprot  = '0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    fill_req = 1'b0;
    fill_cmd = '0;
    lfsr_state   = 32'h2cd5_120b;
    errors       = 0;
    pass_count   = 0;
    fail_count   = 0;
    vec_count    = 0;
    fill_pending = 1'b0;
    fill_busy    = 1'b0;
    cur_op       = "reset";
    for (int w = 0; w < 256; w++) begin
      known[w] = 1'b0;
    end
    load_golden(load_ok);
    if (!load_ok) begin
      $display("could not read any operation from sim/golden_vectors.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      repeat (8) @(posedge s00_axi_aclk);
      #2;
      s00_axi_aresetn = 1'b1;
      @(negedge s00_axi_aclk);
      errs_before = errors;
      expect_low("s00_axi_arready_o", arready);
      expect_low("s00_axi_awready_o", awready);
      expect_low("s00_axi_wready_o", wready);
      expect_low("s00_axi_rvalid_o", rvalid);
      expect_low("s00_axi_bvalid_o", bvalid);
      expect_low("fill_ack_o", fill_ack);
      end_test(0, "outputs low after reset", errs_before);
      for (int i = 0; i < vecs.size(); i++) begin
        v = vecs[i];
        errs_before = errors;
        cur_op = $sformatf("line %0d operation %c", i + 1, v.op);
        case (v.op)
          "W": begin
            axi_write(v.addr, v.data, v.aux[3:0]);
            model_write(v.addr, v.data, v.aux[3:0]);
            end_test(i + 1, $sformatf("W addr %h data %h strb %h",
                     v.addr, v.data, v.aux[3:0]), errs_before);
          end
          "R": begin
            axi_read(v.addr, rd);
            assert (rd === v.exp_data) else begin
              $display("mismatch s00_axi_rdata_o: got %h expected %h", rd, v.exp_data);
              errors++;
            end
            model_check(v.addr, v.exp_data);
            end_test(i + 1, $sformatf("R addr %h", v.addr), errs_before);
          end
          "F": begin
            if (fill_pending) begin
              finish_fill();
            end
            start_fill(i + 1, v);
          end
          default: begin
            $display("unknown operation %c on golden line %0d", v.op, i + 1);
            errors++;
            end_test(i + 1, "unknown operation", errs_before);
          end
        endcase
      end
      if (fill_pending) begin
        finish_fill();
      end
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // Budget of 300 cycles per golden line
  initial begin
    longint limit_ns;
    wait (vec_count > 0);
    limit_ns = longint'(vec_count) * 300 * 40;
    #(limit_ns);
    $display("timeout: %s never completed", cur_op);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/obi_mem_pkg.sv
logic/axi2obi.sv
logic/fill_engine.sv
logic/obi_arbiter.sv
logic/obi_sram.sv
logic/axi_obi_subsys.sv
+incdir+sim
sim/tb_axi_obi_subsys.sv

//--- sim/golden_vectors.txt
# op  addr/base  data/pattern  strb/count  expected read data (all hex)
# W writes, R reads and compares, F starts a fill that runs beside the next lines
W 00000010 deadbeef f 00000000
R 00000010 00000000 0 deadbeef
W 00000414 12345678 f 00000000
R 00000014 00000000 0 12345678
W 00001c20 cafef00d f 00000000
R 00000020 00000000 0 cafef00d
W 00000010 00001100 2 00000000
R 00000010 00000000 0 dead11ef
W 00000020 77000033 9 00000000
R 00000420 00000000 0 77fef033
F 000000fa 10000000 00c 00000000
W 000000c0 0badf00d f 00000000
R 00000020 00000000 0 77fef033
R 000000c0 00000000 0 0badf00d
F 00000040 a0000000 040 00000000
W 00000300 55aa55aa f 00000000
R 00000300 00000000 0 55aa55aa
W 00000300 ffffffff 4 00000000
R 00000300 00000000 0 55ff55aa
R 00000010 00000000 0 1000000a
